// ==== source/lut_pkg.sv ====
package lut_pkg;

   localparam int DATA_W       = 32;  // Lookup result
   localparam int ENTRY_W      = 16;  // One table entry
   localparam int BUS_DATA_W   = 32;  // Bus beat and RAM word
   localparam int LANES        = 2;   // Entries per RAM word
   localparam int SEL_W        = 1;   // Lane select bits in the index
   localparam int TABLE_ADDR_W = 9;   // MSB is the bank
   localparam int BUS_ADDR_W   = 32;
   localparam int LEN_W        = 8;   // Beats minus one
   localparam int GEN_W        = 16;  // Generator counters and settings
   localparam int CFG_ADDR_W   = 3;

   // Software register map
   typedef enum logic [CFG_ADDR_W-1:0] {
      REG_EXT_ADDR,
      REG_ITER,
      REG_PERIOD,
      REG_DUTY,
      REG_SHIFT,
      REG_INCR,
      REG_LENGTH,
      REG_CTRL     // Bit 0 ping_pong, bit 1 disabled
   } cfg_reg_e;

   typedef enum logic {
      LOAD_IDLE,
      LOAD_BURST
   } load_state_e;

endpackage

// ==== source/lut_if.sv ====
`timescale 1ns/1ps

// One port of the table RAM
interface lut_ram_if;
   import lut_pkg::*;

   logic [TABLE_ADDR_W-1:0] addr;
   logic [BUS_DATA_W-1:0]   wdata;
   logic [BUS_DATA_W-1:0]   rdata;
   logic                    en;
   logic                    we;

   modport ctrl (output addr, output wdata, output en, output we, input rdata);
   modport mem  (input addr, input wdata, input en, input we, output rdata);
endinterface

// Settings from the register block
interface lut_cfg_if;
   import lut_pkg::*;

   logic [BUS_ADDR_W-1:0] ext_addr;
   logic [GEN_W-1:0]      iter;
   logic [GEN_W-1:0]      period;
   logic [GEN_W-1:0]      duty;
   logic [GEN_W-1:0]      shift;
   logic [GEN_W-1:0]      incr;
   logic [LEN_W-1:0]      length;
   logic                  ping_pong;
   logic                  disabled;
   logic                  bank;      // Bank being loaded

   modport regs (output ext_addr, iter, period, duty, shift, incr, length,
                 output ping_pong, disabled, bank);
   modport user (input ext_addr, iter, period, duty, shift, incr, length,
                 input ping_pong, disabled, bank);
endinterface

// ==== source/lut_config_regs.sv ====
`timescale 1ns/1ps

module lut_config_regs (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cfg_we_i,
   input  lut_pkg::cfg_reg_e          cfg_addr_i,
   input  logic [lut_pkg::DATA_W-1:0] cfg_wdata_i,
   input  logic                       run_i,
   lut_cfg_if.regs                    cfg
);
   import lut_pkg::*;

   // Software writes, one register per index
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg.ext_addr  <= '0;
         cfg.iter      <= '0;
         cfg.period    <= '0;
         cfg.duty      <= '0;
         cfg.shift     <= '0;
         cfg.incr      <= '0;
         cfg.length    <= '0;
         cfg.ping_pong <= 1'b0;
         cfg.disabled  <= 1'b0;
      end else if (cfg_we_i) begin
         case (cfg_addr_i)
            REG_EXT_ADDR: cfg.ext_addr <= cfg_wdata_i[BUS_ADDR_W-1:0];
            REG_ITER:     cfg.iter     <= cfg_wdata_i[GEN_W-1:0];
            REG_PERIOD:   cfg.period   <= cfg_wdata_i[GEN_W-1:0];
            REG_DUTY:     cfg.duty     <= cfg_wdata_i[GEN_W-1:0];
            REG_SHIFT:    cfg.shift    <= cfg_wdata_i[GEN_W-1:0];
            REG_INCR:     cfg.incr     <= cfg_wdata_i[GEN_W-1:0];
            REG_LENGTH:   cfg.length   <= cfg_wdata_i[LEN_W-1:0];
            REG_CTRL: begin
               cfg.ping_pong <= cfg_wdata_i[0];
               cfg.disabled  <= cfg_wdata_i[1];
            end
            default: ;
         endcase
      end
   end

   // Bank flips per run in ping-pong mode
   // Lookups read the other bank
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg.bank <= 1'b0;
      end else if (run_i) begin
         cfg.bank <= cfg.ping_pong ? ~cfg.bank : 1'b0;
      end
   end

endmodule

// ==== source/lut_load_addr_gen.sv ====
`timescale 1ns/1ps

module lut_load_addr_gen (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             start_i,
   input  logic                             advance_i,
   lut_cfg_if.user                          cfg,
   output logic                             valid_o,
   output logic [lut_pkg::TABLE_ADDR_W-1:0] addr_o
);
   import lut_pkg::*;

   logic             busy;
   logic [GEN_W-1:0] iter_cnt;   // Periods completed
   logic [GEN_W-1:0] per_cnt;    // Step within the period
   logic [GEN_W-1:0] addr;
   logic             in_duty;
   logic             step;
   logic             last_step;
   logic             last_iter;
   logic [GEN_W-1:0] addr_step;

   assign in_duty   = per_cnt < cfg.duty;
   assign last_step = per_cnt == cfg.period - 1'b1;
   assign last_iter = iter_cnt == cfg.iter - 1'b1;

   // Duty steps wait for the consumer, the rest run one per cycle
   assign step      = busy && (in_duty ? advance_i : 1'b1);
   assign addr_step = in_duty ? cfg.incr : '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy     <= 1'b0;
         iter_cnt <= '0;
         per_cnt  <= '0;
         addr     <= '0;
      end else if (start_i) begin
         busy     <= (cfg.iter != '0) && (cfg.period != '0);  // Empty pattern never starts
         iter_cnt <= '0;
         per_cnt  <= '0;
         addr     <= '0;
      end else if (step) begin
         if (last_step) begin
            per_cnt <= '0;
            addr    <= addr + addr_step + cfg.shift;  // Jump to next period base
            if (last_iter) begin
               busy <= 1'b0;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr    <= addr + addr_step;
         end
      end
   end

   assign valid_o = busy && in_duty;

   // Bank bit is added by the loader
   assign addr_o  = {1'b0, addr[TABLE_ADDR_W-2:0]};

endmodule

// ==== source/lut_loader.sv ====
`timescale 1ns/1ps

module lut_loader (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           run_i,
   lut_cfg_if.user                        cfg,
   output logic                           bus_valid_o,
   input  logic                           bus_ready_i,
   output logic [lut_pkg::BUS_ADDR_W-1:0] bus_addr_o,
   output logic [lut_pkg::LEN_W-1:0]      bus_len_o,
   input  logic [lut_pkg::BUS_DATA_W-1:0] bus_rdata_i,
   input  logic                           bus_last_i,
   lut_ram_if.ctrl                        wr,
   output logic                           done_o
);
   import lut_pkg::*;

   load_state_e             state;
   logic                    start;
   logic                    beat;
   logic                    gen_valid;
   logic [TABLE_ADDR_W-1:0] gen_addr;
   logic                    bank_bit;

   assign start = run_i && !cfg.disabled;
   assign beat  = bus_valid_o && bus_ready_i;  // One word lands in the RAM

   lut_load_addr_gen addr_gen0 (
      .clk      (clk),
      .rst      (rst),
      .start_i  (start),
      .advance_i(beat),
      .cfg      (cfg),
      .valid_o  (gen_valid),
      .addr_o   (gen_addr)
   );

   // Burst tracking and done flag
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= LOAD_IDLE;
         done_o <= 1'b1;
      end else if (start) begin
         state  <= LOAD_BURST;
         done_o <= 1'b0;
      end else if (beat && bus_last_i) begin
         state  <= LOAD_IDLE;
         done_o <= 1'b1;
      end
   end

   // Request fields stay fixed during the burst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr_o <= '0;
         bus_len_o  <= '0;
      end else if (start) begin
         bus_addr_o <= cfg.ext_addr;
         bus_len_o  <= cfg.length;
      end
   end

   // Only ask for a beat when there is somewhere to put it
   assign bus_valid_o = (state == LOAD_BURST) && gen_valid;

   assign bank_bit = cfg.ping_pong ? cfg.bank : 1'b0;

   // Write side of the table RAM
   assign wr.en    = beat;
   assign wr.we    = 1'b1;
   assign wr.wdata = bus_rdata_i;
   assign wr.addr  = {bank_bit, gen_addr[TABLE_ADDR_W-2:0]};

endmodule

// ==== source/lut_lane_reader.sv ====
`timescale 1ns/1ps

module lut_lane_reader (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [lut_pkg::DATA_W-1:0] lookup_idx_i,
   lut_cfg_if.user                    cfg,
   lut_ram_if.ctrl                    rd,
   output logic [lut_pkg::DATA_W-1:0] lookup_data_o
);
   import lut_pkg::*;

   logic [SEL_W-1:0]                sel_q1;  // Lines up with rd.addr
   logic [SEL_W-1:0]                sel_q2;  // Lines up with rd.rdata
   logic [LANES-1:0][ENTRY_W-1:0]   lanes;
   logic [ENTRY_W-1:0]              entry;

   // Read the bank that is not being loaded
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd.addr <= '0;
      end else begin
         rd.addr <= {cfg.ping_pong && !cfg.bank,
                     lookup_idx_i[SEL_W +: TABLE_ADDR_W-1]};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sel_q1 <= '0;
         sel_q2 <= '0;
      end else begin
         sel_q1 <= lookup_idx_i[SEL_W-1:0];
         sel_q2 <= sel_q1;
      end
   end

   // Read port is never written
   assign rd.en    = 1'b1;
   assign rd.we    = 1'b0;
   assign rd.wdata = '0;

   // Lane 0 sits in the low half
   assign lanes = rd.rdata;
   assign entry = lanes[sel_q2];

   assign lookup_data_o = {{(DATA_W-ENTRY_W){1'b0}}, entry};  // Zero extend

endmodule

// ==== source/lut_dp_ram.sv ====
`timescale 1ns/1ps

module lut_dp_ram (
   input  logic    clk,
   lut_ram_if.mem  rd,
   lut_ram_if.mem  wr
);
   import lut_pkg::*;

   logic [BUS_DATA_W-1:0] mem [1 << TABLE_ADDR_W];  // Both banks

   // Loader writes through wr, lookups read through rd
   always_ff @(posedge clk) begin
      if (wr.en && wr.we) begin
         mem[wr.addr] <= wr.wdata;
      end
      if (rd.en) begin
         rd.rdata <= mem[rd.addr];  // Old data on a same-cycle collision
      end
   end

endmodule

// ==== source/lut_unit_top.sv ====
`timescale 1ns/1ps

module lut_unit_top (
   input  logic                           clk,
   input  logic                           rst,

   // Software register writes
   input  logic                           cfg_we_i,
   input  lut_pkg::cfg_reg_e              cfg_addr_i,
   input  logic [lut_pkg::DATA_W-1:0]     cfg_wdata_i,
   input  logic                           run_i,
   output logic                           done_o,

   // Read-only data bus
   output logic                           bus_valid_o,
   input  logic                           bus_ready_i,
   output logic [lut_pkg::BUS_ADDR_W-1:0] bus_addr_o,
   output logic [lut_pkg::LEN_W-1:0]      bus_len_o,
   input  logic [lut_pkg::BUS_DATA_W-1:0] bus_rdata_i,
   input  logic                           bus_last_i,

   // Lookup stream
   input  logic [lut_pkg::DATA_W-1:0]     lookup_idx_i,
   output logic [lut_pkg::DATA_W-1:0]     lookup_data_o
);

   lut_ram_if rd_port ();
   lut_ram_if wr_port ();
   lut_cfg_if cfg_bus ();

   lut_config_regs regs0 (
      .clk        (clk),
      .rst        (rst),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_wdata_i(cfg_wdata_i),
      .run_i      (run_i),
      .cfg        (cfg_bus.regs)
   );

   lut_loader loader0 (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run_i),
      .cfg        (cfg_bus.user),
      .bus_valid_o(bus_valid_o),
      .bus_ready_i(bus_ready_i),
      .bus_addr_o (bus_addr_o),
      .bus_len_o  (bus_len_o),
      .bus_rdata_i(bus_rdata_i),
      .bus_last_i (bus_last_i),
      .wr         (wr_port.ctrl),
      .done_o     (done_o)
   );

   lut_lane_reader reader0 (
      .clk          (clk),
      .rst          (rst),
      .lookup_idx_i (lookup_idx_i),
      .cfg          (cfg_bus.user),
      .rd           (rd_port.ctrl),
      .lookup_data_o(lookup_data_o)
   );

   lut_dp_ram ram0 (
      .clk(clk),
      .rd (rd_port.mem),
      .wr (wr_port.mem)
   );

endmodule

// ==== test/tb_lut_unit.sv ====
`timescale 1ns/1ps

module tb_lut_unit;
   import lut_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RUN_CYCLES = 400;  // Upper bound for one run with back-pressure

   logic                    clk;
   logic                    rst;
   logic                    cfg_we_i;
   cfg_reg_e                cfg_addr_i;
   logic [DATA_W-1:0]       cfg_wdata_i;
   logic                    run_i;
   logic                    done_o;
   logic                    bus_valid_o;
   logic                    bus_ready_i;
   logic [BUS_ADDR_W-1:0]   bus_addr_o;
   logic [LEN_W-1:0]        bus_len_o;
   logic [BUS_DATA_W-1:0]   bus_rdata_i;
   logic                    bus_last_i;
   logic [DATA_W-1:0]       lookup_idx_i;
   logic [DATA_W-1:0]       lookup_data_o;

   logic [BUS_DATA_W-1:0]   ext_mem [256];  // Bus memory model contents
   logic                    bp_random;
   int                      beat_idx;
   int                      total_beats;
   logic                    last_beat_seen;
   logic                    run_seen;
   int                      limit_cycles;

   // Lookup check pipeline
   logic                    pend_valid;
   logic [DATA_W-1:0]       pend_exp;
   logic [DATA_W-1:0]       pend_idx;
   logic [1:0]              stage_valid;
   logic [DATA_W-1:0]       stage_exp [2];
   logic [DATA_W-1:0]       stage_idx [2];

   lut_unit_top dut0 (
      .clk          (clk),
      .rst          (rst),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .run_i        (run_i),
      .done_o       (done_o),
      .bus_valid_o  (bus_valid_o),
      .bus_ready_i  (bus_ready_i),
      .bus_addr_o   (bus_addr_o),
      .bus_len_o    (bus_len_o),
      .bus_rdata_i  (bus_rdata_i),
      .bus_last_i   (bus_last_i),
      .lookup_idx_i (lookup_idx_i),
      .lookup_data_o(lookup_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check_lookup(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] idx);
      if (got !== exp) begin
         report_error($sformatf("lookup index %0h gave %08h, expected %08h", idx, got, exp));
      end
   endtask

   task automatic check_done(input logic got, input logic exp, input string when);
      if (got !== exp) begin
         report_error($sformatf("done_o is %b %s, expected %b", got, when, exp));
      end
   endtask

   // Bus memory model, one beat per accepted valid/ready cycle
   always @(posedge clk) begin
      if (run_i) begin
         beat_idx = 0;
         last_beat_seen = 1'b0;
         bus_ready_i <= 1'b0;  // Hold off until bus_addr_o is latched
         bus_last_i  <= 1'b0;
      end else begin
         if (bus_valid_o && bus_ready_i) begin
            total_beats = total_beats + 1;
            if (bus_last_i) last_beat_seen = 1'b1;
            beat_idx = beat_idx + 1;
         end
         bus_ready_i <= bp_random ? 1'($urandom % 2) : 1'b1;
         bus_rdata_i <= ext_mem[8'(bus_addr_o + 32'(beat_idx))];
         bus_last_i  <= (beat_idx == int'(bus_len_o));
      end
   end

   // No bus requests before the first run
   always @(posedge clk) begin
      if (!rst && !run_seen && bus_valid_o) begin
         report_error("bus_valid_o high before any run");
      end
   end

   // Results come out two cycles after the index is sampled
   always @(posedge clk) begin
      if (stage_valid[1]) check_lookup(lookup_data_o, stage_exp[1], stage_idx[1]);
      stage_valid[0] <= pend_valid;
      stage_exp[0]   <= pend_exp;
      stage_idx[0]   <= pend_idx;
      stage_valid[1] <= stage_valid[0];
      stage_exp[1]   <= stage_exp[0];
      stage_idx[1]   <= stage_idx[0];
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("*** TEST FAILED ***");
      $fatal(1);
   end

   task automatic count_commands(output int runs, output int lookups, output int others);
      int                 fd;
      int                 code;
      logic [8*16-1:0]    cmd;
      logic [8*256-1:0]   line;
      runs = 0;
      lookups = 0;
      others = 0;
      fd = $fopen("test/lut_vectors.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test/lut_vectors.txt");
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", cmd);
         if (code == 1) begin
            if (cmd == "R") runs++;
            else if (cmd == "L") lookups++;
            else others++;
         end
         code = $fgets(line, fd);  // Rest of the line
      end
      $fclose(fd);
   endtask

   task automatic write_reg(input logic [31:0] idx, input logic [31:0] data);
      @(posedge clk);
      pend_valid  <= 1'b0;
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= cfg_reg_e'(idx[CFG_ADDR_W-1:0]);
      cfg_wdata_i <= data;
      @(posedge clk);
      cfg_we_i    <= 1'b0;
   endtask

   task automatic run_load(input int exp_beats);
      int start_beats;
      start_beats = total_beats;
      @(posedge clk);
      pend_valid <= 1'b0;
      run_i      <= 1'b1;
      run_seen   <= 1'b1;
      @(posedge clk);
      run_i      <= 1'b0;
      @(posedge clk);
      if (exp_beats == 0) begin
         check_done(done_o, 1'b1, "after a disabled run");
         repeat (10) @(posedge clk);
         check_done(done_o, 1'b1, "after a disabled run");
      end else begin
         check_done(done_o, 1'b0, "after run start");
         while (done_o !== 1'b1) @(posedge clk);
         if (!last_beat_seen) report_error("done_o rose before the last beat");
      end
      if (total_beats - start_beats != exp_beats) begin
         report_error($sformatf("run moved %0d beats, expected %0d",
                                total_beats - start_beats, exp_beats));
      end
   endtask

   task automatic give_lookup(input logic [31:0] idx, input logic [31:0] exp);
      @(posedge clk);
      lookup_idx_i <= idx;
      pend_valid   <= 1'b1;
      pend_exp     <= exp;
      pend_idx     <= idx;
   endtask

   initial begin
      int               fd;
      int               code;
      int               runs;
      int               lookups;
      int               others;
      logic [8*16-1:0]  cmd;
      logic [8*256-1:0] line;
      logic [31:0]      a;
      logic [31:0]      b;

      void'($urandom(15));
      rst          = 1'b1;
      cfg_we_i     = 1'b0;
      cfg_addr_i   = REG_EXT_ADDR;
      cfg_wdata_i  = '0;
      run_i        = 1'b0;
      bus_ready_i  = 1'b0;
      bus_rdata_i  = '0;
      bus_last_i   = 1'b0;
      lookup_idx_i = '0;
      bp_random    = 1'b0;
      beat_idx     = 0;
      total_beats  = 0;
      last_beat_seen = 1'b0;
      run_seen     = 1'b0;
      pend_valid   = 1'b0;
      pend_exp     = '0;
      pend_idx     = '0;
      stage_valid  = '0;
      for (int i = 0; i < 256; i++) begin
         ext_mem[i] = {16'hC000 | 16'(i), 16'h1000 | 16'(i)};
      end

      count_commands(runs, lookups, others);
      limit_cycles = 20 + runs * RUN_CYCLES + lookups * 2 + others * 3 + 50;

      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_done(done_o, 1'b1, "after reset");

      fd = $fopen("test/lut_vectors.txt", "r");
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", cmd);
         if (code == 1) begin
            if (cmd == "M") begin
               code = $fscanf(fd, "%h %h", a, b);
               ext_mem[a[7:0]] = b;
            end else if (cmd == "C") begin
               code = $fscanf(fd, "%h %h", a, b);
               write_reg(a, b);
            end else if (cmd == "B") begin
               code = $fscanf(fd, "%h", a);
               bp_random = a[0];
            end else if (cmd == "R") begin
               code = $fscanf(fd, "%h", a);
               run_load(int'(a));
            end else if (cmd == "L") begin
               code = $fscanf(fd, "%h %h", a, b);
               give_lookup(a, b);
            end
         end
         code = $fgets(line, fd);
      end
      $fclose(fd);

      @(posedge clk);
      pend_valid <= 1'b0;
      repeat (4) @(posedge clk);  // Drain lookups in flight
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== all.f ====
source/lut_pkg.sv
source/lut_if.sv
source/lut_config_regs.sv
source/lut_load_addr_gen.sv
source/lut_loader.sv
source/lut_lane_reader.sv
source/lut_dp_ram.sv
source/lut_unit_top.sv
test/tb_lut_unit.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_lut_unit

.PHONY: run clean

$(SIM): all.f $(wildcard source/*.sv) $(wildcard test/*.sv)
	verilator --binary -f all.f --top-module tb_lut_unit -o Vtb_lut_unit

run: $(SIM) test/lut_vectors.txt
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		exit 1; \
	elif grep -qF '*** TEST PASSED ***' sim.log; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== test/lut_vectors.txt ====
# M addr data | C reg data | B random_ready | R beats | L index expected (all hex)
# regs 0 ext_addr 1 iter 2 period 3 duty 4 shift 5 incr 6 length 7 ctrl
M 12 ABCD8765
C 0 10
C 1 1
C 2 4
C 3 4
C 5 1
C 6 3
R 4
L 0 1010
L 1 C010
L 4 8765
L 5 ABCD
L 7 C013
L 6 1013
# strided pattern, words 0 2 5 7
C 0 20
C 1 2
C 2 3
C 3 2
C 4 1
C 5 2
R 4
L 0 1020
L 3 C011
L 4 1021
L b C022
L e 1023
L 7 C013
B 1
R 4
L 0 1020
L 3 C011
L b C022
L e 1023
# ping-pong banks
C 7 1
R 4
L 0 1020
L b C022
C 0 30
R 4
L 0 1020
L b C022
C 0 40
R 4
L 0 1030
L b C032
L 3 C011
# disabled run
C 7 2
R 0
L 0 1030
L b C032
L 3 C011
